// ==== acq_defs.svh ====
`ifndef ACQ_DEFS_SVH
`define ACQ_DEFS_SVH

// payload carried by every stream word, one adc sample or one header
`define PAYLOAD_W 128
// tag sits above the payload in the stream word
`define TAG_W 4

// memory side widths
`define ADDR_W 23
`define COUNT_W 24

// stream buffer holds 64 words
`define FIFO_DEPTH_LOG2 6

// tag encodings, anything else on the stream means framing is lost
`define TAG_FILL_HDR 4'd1
`define TAG_WFM_HDR 4'd2
`define TAG_CKSM 4'd4
`define TAG_ABORT 4'd15

`endif

// ==== acq_pkg.sv ====
`include "acq_defs.svh"

package acq_pkg;

    // one adc sample, also the payload of every stream word
    typedef logic [`PAYLOAD_W-1:0] sample_t;

    // word kinds on the acquisition stream
    typedef enum logic [`TAG_W-1:0] {
        tag_data = '0,
        tag_fill_hdr = `TAG_FILL_HDR,
        tag_wfm_hdr = `TAG_WFM_HDR,
        tag_cksm = `TAG_CKSM,
        tag_abort = `TAG_ABORT
    } tag_t;

    // 132 bit word as it travels through the fifo
    typedef struct packed {
        tag_t tag;
        sample_t payload;
    } stream_word_t;

    // header count fields share the burst address width
    typedef logic [`ADDR_W-1:0] wfm_count_t;
    typedef logic [`ADDR_W-1:0] burst_len_t;

    // fill header layout
    localparam int fill_num_msb = 127;
    localparam int fill_num_lsb = 96;
    localparam int fill_addr_msb = 75;
    localparam int fill_addr_lsb = 53;
    localparam int fill_wfm_msb = 22;
    localparam int fill_wfm_lsb = 0;

    // waveform header layout
    localparam int wfm_len_msb = 22;
    localparam int wfm_len_lsb = 0;
    localparam int wfm_idx_msb = 47;
    localparam int wfm_idx_lsb = 32;

endpackage

// ==== acq_write_top.sv ====
`timescale 1ns/1ps
`include "acq_defs.svh"

module acq_write_top import acq_pkg::*, mem_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic acq_enabled,
    // acquisition side
    input  logic fill_start,
    input  burst_addr_t start_addr,
    input  wfm_count_t wfm_count,
    input  burst_len_t burst_len,
    input  logic adc_valid,
    input  sample_t adc_dat,
    output logic overrun,
    // memory user interface
    output logic app_en,
    input  logic app_rdy,
    output byte_addr_t app_addr,
    output logic app_wdf_wren,
    input  logic app_wdf_rdy,
    output logic app_wdf_end,
    output sample_t app_wdf_data,
    input  burst_addr_t fixed_start_addr,
    input  logic use_fixed_start_addr,
    // fill record and status
    output logic rec_wr_en,
    output fill_rec_t rec_data,
    output logic sync_err,
    output logic wr_done
);

    logic push;
    logic pop;
    logic empty;
    logic acq_done;
    stream_word_t push_word;
    stream_word_t head_word;

    fill_formatter u_formatter (
        .clk(clk), .reset(reset), .fill_start(fill_start), .start_addr(start_addr),
        .wfm_count(wfm_count), .burst_len(burst_len), .adc_valid(adc_valid),
        .adc_dat(adc_dat), .push(push), .push_word(push_word), .acq_done(acq_done),
        .overrun(overrun)
    );

    // a fill is shorter than the buffer, so full stays internal
    stream_fifo #(.DEPTH_LOG2(`FIFO_DEPTH_LOG2)) u_fifo (
        .clk(clk), .reset(reset), .push(push), .push_word(push_word), .pop(pop),
        .head_word(head_word), .empty(empty), .full()
    );

    ddr3_wr_control u_wr_control (
        .clk(clk), .reset(reset), .acq_enabled(acq_enabled), .head_word(head_word),
        .empty(empty), .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
        .fixed_start_addr(fixed_start_addr), .use_fixed_start_addr(use_fixed_start_addr),
        .acq_done(acq_done), .pop(pop), .app_en(app_en), .app_addr(app_addr),
        .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data),
        .rec_wr_en(rec_wr_en), .rec_data(rec_data), .sync_err(sync_err), .wr_done(wr_done)
    );

endmodule

// ==== ddr3_wr_control.sv ====
`timescale 1ns/1ps

module ddr3_wr_control import acq_pkg::*, mem_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic acq_enabled,
    input  stream_word_t head_word,
    input  logic empty,
    input  logic app_rdy,
    input  logic app_wdf_rdy,
    input  burst_addr_t fixed_start_addr,
    input  logic use_fixed_start_addr,
    input  logic acq_done,
    output logic pop,
    output logic app_en,
    output byte_addr_t app_addr,
    output logic app_wdf_wren,
    output logic app_wdf_end,
    output sample_t app_wdf_data,
    output logic rec_wr_en,
    output fill_rec_t rec_data,
    output logic sync_err,
    output logic wr_done
);

    typedef enum logic [3:0] {
        st_idle,
        st_tst_tag,
        st_sync_err,
        st_init_fill,
        st_init_wfm,
        st_init_cksm,
        st_write,
        st_write_cksm,
        st_write_rec,
        st_done
    } wr_state_t;

    wr_state_t state;
    wr_state_t next_state;
    logic acq_done_s1;
    logic acq_done_s2;
    logic writing;
    logic address_accept;
    logic data_accept;
    logic addr_zero;
    logic burst_zero;
    logic addr_last;
    logic burst_last;
    logic seg_load;
    burst_count_t seg_init;
    burst_count_t addr_cnt;
    burst_count_t burst_cnt;
    burst_count_t throttle;
    burst_count_t total_bursts;
    burst_addr_t addr_gen;
    sample_t fill_hdr_q;

    // producer done level, two flops before the FSM looks at it
    always_ff @(posedge clk) begin
        if (reset) begin
            acq_done_s1 <= 1'b0;
            acq_done_s2 <= 1'b0;
        end else begin
            acq_done_s1 <= acq_done;
            acq_done_s2 <= acq_done_s1;
        end
    end

    assign writing = (state == st_write || state == st_write_cksm);
    assign address_accept = app_en && app_rdy;
    assign data_accept = app_wdf_wren && app_wdf_rdy;
    assign addr_zero = (addr_cnt == '0);
    assign burst_zero = (burst_cnt == '0);
    // counter reaches zero at the end of this cycle
    assign addr_last = (addr_cnt == burst_count_t'(address_accept));
    assign burst_last = (burst_cnt == burst_count_t'(data_accept));

    // fill header and checksum are one burst each
    // a waveform is its header plus burst length data words
    assign seg_load = (state == st_init_fill || state == st_init_wfm || state == st_init_cksm);
    assign seg_init = (state == st_init_wfm)
        ? burst_count_t'(head_word.payload[wfm_len_msb:wfm_len_lsb]) + 1'b1
        : burst_count_t'(1);

    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // head is valid once empty is low
            st_idle: if (!empty) next_state = st_tst_tag;
            st_tst_tag: begin
                case (head_word.tag)
                    tag_fill_hdr: next_state = st_init_fill;
                    tag_wfm_hdr: next_state = st_init_wfm;
                    tag_cksm: next_state = st_init_cksm;
                    // data or abort where a header belongs
                    default: next_state = st_sync_err;
                endcase
            end
            // held until acq_enabled drops
            st_sync_err: next_state = st_sync_err;
            st_init_fill, st_init_wfm: next_state = st_write;
            st_init_cksm: next_state = st_write_cksm;
            st_write: if (addr_zero && burst_zero) next_state = st_idle;
            st_write_cksm: if (addr_last && burst_last) next_state = st_write_rec;
            st_write_rec: next_state = st_done;
            st_done: if (acq_done_s2) next_state = st_idle;
            default: next_state = st_idle;
        endcase
    end

    // segment counters, one for addresses and one for data
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_cnt <= '0;
            burst_cnt <= '0;
        end else if (seg_load) begin
            addr_cnt <= seg_init;
            burst_cnt <= seg_init;
        end else begin
            if (address_accept) begin
                addr_cnt <= addr_cnt - 1'b1;
            end
            if (data_accept) begin
                burst_cnt <= burst_cnt - 1'b1;
            end
        end
    end

    // data accepted minus addresses accepted
    // an address may only go out for data already taken
    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            throttle <= '0;
        end else if (data_accept && !address_accept) begin
            throttle <= throttle + 1'b1;
        end else if (address_accept && !data_accept) begin
            throttle <= throttle - 1'b1;
        end
    end

    // burst address and fill total, both restart at the fill header
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_gen <= '0;
            total_bursts <= '0;
        end else if (state == st_init_fill) begin
            addr_gen <= use_fixed_start_addr ? fixed_start_addr
                : head_word.payload[fill_addr_msb:fill_addr_lsb];
            total_bursts <= '0;
        end else if (address_accept) begin
            addr_gen <= addr_gen + 1'b1;
            total_bursts <= total_bursts + 1'b1;
        end
    end

    // fill header kept for the record, head is still unpopped here
    always_ff @(posedge clk) begin
        if (state == st_init_fill) begin
            fill_hdr_q <= head_word.payload;
        end
    end

    assign app_en = writing && throttle != '0 && !addr_zero;
    assign app_addr = {addr_gen, 3'b000};
    assign app_wdf_wren = writing && !empty && !burst_zero;
    // single word bursts, every data beat is also the last
    assign app_wdf_end = app_wdf_wren;
    assign app_wdf_data = head_word.payload;
    // accepted data frees the head for the next word
    assign pop = data_accept;

    assign rec_wr_en = (state == st_write_rec);
    assign rec_data = '{total: total_bursts, header: fill_hdr_q};
    assign wr_done = (state == st_done);
    assign sync_err = (state == st_sync_err);

    // between segments every accepted data word has had its address
    a_idle_balanced: assert property (@(posedge clk) disable iff (reset)
        state == st_idle |-> throttle == '0);

endmodule

// ==== fill_formatter.sv ====
`timescale 1ns/1ps

module fill_formatter import acq_pkg::*, mem_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic fill_start,
    input  burst_addr_t start_addr,
    input  wfm_count_t wfm_count,
    input  burst_len_t burst_len,
    input  logic adc_valid,
    input  sample_t adc_dat,
    output logic push,
    output stream_word_t push_word,
    output logic acq_done,
    output logic overrun
);

    typedef enum logic [2:0] {
        st_idle,
        st_fill_hdr,
        st_wfm_hdr,
        st_samples,
        st_cksm,
        st_done
    } fmt_state_t;

    fmt_state_t state;
    burst_addr_t hdr_addr;
    wfm_count_t n_wfm;
    wfm_count_t wfm_idx;
    burst_len_t cur_len;
    burst_len_t smp_cnt;
    logic [fill_num_msb-fill_num_lsb:0] fill_num;
    sample_t data_q;
    sample_t cksum;
    sample_t fill_hdr;
    sample_t wfm_hdr;
    logic data_push;
    logic collide;
    logic take_sample;

    // header states push every cycle, so a sample there has no slot
    assign collide = adc_valid && (state == st_fill_hdr || state == st_wfm_hdr);
    // samples beyond the burst length are not taken
    assign take_sample = adc_valid && state == st_samples && smp_cnt != cur_len;

    // header payloads, unused bits stay zero
    always_comb begin
        fill_hdr = '0;
        fill_hdr[fill_num_msb:fill_num_lsb] = fill_num;
        fill_hdr[fill_addr_msb:fill_addr_lsb] = hdr_addr;
        fill_hdr[fill_wfm_msb:fill_wfm_lsb] = n_wfm;
        wfm_hdr = '0;
        // burst length is taken live, it is allowed to change per waveform
        wfm_hdr[wfm_len_msb:wfm_len_lsb] = burst_len;
        wfm_hdr[wfm_idx_msb:wfm_idx_lsb] = wfm_idx[wfm_idx_msb-wfm_idx_lsb:0];
    end

    // headers and checksum are pushed in their own state cycle
    // data words go out one cycle after the sample
    always_comb begin
        push = 1'b1;
        push_word = '{tag: tag_data, payload: data_q};
        case (state)
            st_fill_hdr: push_word = '{tag: tag_fill_hdr, payload: fill_hdr};
            st_wfm_hdr: push_word = '{tag: tag_wfm_hdr, payload: wfm_hdr};
            st_cksm: push_word = '{tag: tag_cksm, payload: cksum};
            default: push = data_push;
        endcase
        // the colliding header is replaced so the consumer drops sync
        if (collide) begin
            push_word = '{tag: tag_abort, payload: '0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            acq_done <= 1'b0;
            overrun <= 1'b0;
            data_push <= 1'b0;
            fill_num <= '0;
            wfm_idx <= '0;
            smp_cnt <= '0;
        end else begin
            data_push <= take_sample;
            case (state)
                st_idle, st_done: begin
                    if (fill_start) begin
                        acq_done <= 1'b0;
                        wfm_idx <= '0;
                        state <= st_fill_hdr;
                    end
                end
                st_fill_hdr: begin
                    fill_num <= fill_num + 1'b1;
                    if (collide) begin
                        overrun <= 1'b1;
                        state <= st_idle;
                    end else if (n_wfm == '0) begin
                        state <= st_cksm;
                    end else begin
                        state <= st_wfm_hdr;
                    end
                end
                st_wfm_hdr: begin
                    wfm_idx <= wfm_idx + 1'b1;
                    smp_cnt <= '0;
                    if (collide) begin
                        overrun <= 1'b1;
                        state <= st_idle;
                    end else begin
                        state <= st_samples;
                    end
                end
                st_samples: begin
                    // wait one more cycle so the last data word goes out first
                    if (smp_cnt == cur_len) begin
                        state <= (wfm_idx == n_wfm) ? st_cksm : st_wfm_hdr;
                    end else if (take_sample) begin
                        smp_cnt <= smp_cnt + 1'b1;
                    end
                end
                st_cksm: begin
                    acq_done <= 1'b1;
                    state <= st_done;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // per fill payload registers
    always_ff @(posedge clk) begin
        if (fill_start && (state == st_idle || state == st_done)) begin
            hdr_addr <= start_addr;
            n_wfm <= wfm_count;
            cksum <= '0;
        end else if (take_sample) begin
            cksum <= cksum ^ adc_dat;
        end
        if (take_sample) begin
            data_q <= adc_dat;
        end
        if (state == st_wfm_hdr) begin
            cur_len <= burst_len;
        end
    end

    // fill_start arriving in the middle of a fill would be dropped
    a_start_between_fills: assert property (@(posedge clk) disable iff (reset)
        fill_start |-> state == st_idle || state == st_done);

endmodule

// ==== mem_pkg.sv ====
`include "acq_defs.svh"

package mem_pkg;

    // memory is addressed in whole bursts of one stream word each
    typedef logic [`ADDR_W-1:0] burst_addr_t;

    // user interface wants a byte address, eight bytes per burst step
    typedef logic [`ADDR_W+2:0] byte_addr_t;

    // bursts written in one fill
    typedef logic [`COUNT_W-1:0] burst_count_t;

    // one entry per completed fill
    // total covers fill header, waveform headers, data and checksum
    typedef struct packed {
        burst_count_t total;
        logic [`PAYLOAD_W-1:0] header;
    } fill_rec_t;

endpackage

// ==== src.f ====
+incdir+.
acq_pkg.sv
mem_pkg.sv
fill_formatter.sv
stream_fifo.sv
ddr3_wr_control.sv
acq_write_top.sv
tb_acq_write.sv

// ==== stream_fifo.sv ====
`timescale 1ns/1ps
`include "acq_defs.svh"

module stream_fifo import acq_pkg::*; #(
    parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  stream_word_t push_word,
    input  logic pop,
    output stream_word_t head_word,
    output logic empty,
    output logic full
);

    localparam int depth = 2 ** DEPTH_LOG2;

    stream_word_t mem [depth];
    // one extra bit tells full from empty when the indexes match
    logic [DEPTH_LOG2:0] wr_ptr;
    logic [DEPTH_LOG2:0] rd_ptr;
    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= push_word;
        end
    end

    // fall through, the head is valid as soon as empty drops
    assign head_word = mem[rd_ptr[DEPTH_LOG2-1:0]];
    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2])
        && (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

    // producer and consumer both pace themselves on the flags
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);
    a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);

endmodule

// ==== tb_acq_write.sv ====
`timescale 1ns/1ps

module tb_acq_write import acq_pkg::*, mem_pkg::*;;

    // four clean fills and one collision fill
    localparam int num_fills = 5;
    localparam int cycle_limit = 400 * num_fills + 200;

    logic clk = 1'b0;
    logic reset;
    logic acq_enabled;
    logic fill_start;
    burst_addr_t start_addr;
    wfm_count_t wfm_count;
    burst_len_t burst_len;
    logic adc_valid;
    sample_t adc_dat;
    logic overrun;
    logic app_en;
    logic app_rdy;
    byte_addr_t app_addr;
    logic app_wdf_wren;
    logic app_wdf_rdy;
    logic app_wdf_end;
    sample_t app_wdf_data;
    burst_addr_t fixed_start_addr;
    logic use_fixed_start_addr;
    logic rec_wr_en;
    fill_rec_t rec_data;
    logic sync_err;
    logic wr_done;

    // expected stream, addresses and records, filled while driving
    sample_t exp_data [$];
    byte_addr_t exp_addr [$];
    fill_rec_t exp_rec [$];

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int rec_cnt = 0;
    int recs_expected = 0;
    int data_words = 0;
    int addr_words = 0;
    int fill_idx = 0;
    logic rec_prev = 1'b0;
    logic [31:0] lfsr = 32'd56;

    acq_write_top UUT (
        .clk(clk), .reset(reset), .acq_enabled(acq_enabled), .fill_start(fill_start),
        .start_addr(start_addr), .wfm_count(wfm_count), .burst_len(burst_len),
        .adc_valid(adc_valid), .adc_dat(adc_dat), .overrun(overrun), .app_en(app_en),
        .app_rdy(app_rdy), .app_addr(app_addr), .app_wdf_wren(app_wdf_wren),
        .app_wdf_rdy(app_wdf_rdy), .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data),
        .fixed_start_addr(fixed_start_addr), .use_fixed_start_addr(use_fixed_start_addr),
        .rec_wr_en(rec_wr_en), .rec_data(rec_data), .sync_err(sync_err), .wr_done(wr_done)
    );

    always #5 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [151:0] got,
                               input logic [151:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // every input change lands 1 ns after the edge
    // memory model readies are redrawn each cycle here
    task automatic next_cycle();
        @(posedge clk);
        #1;
        // memory takes about three beats in four
        app_rdy = rand_bits(2) != 0;
        app_wdf_rdy = rand_bits(2) != 0;
    endtask

    // memory side monitor, values are settled at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            // counts so far are from earlier cycles, this one not yet added
            if (app_en && data_words <= addr_words) begin
                errors++;
                $display("address offered before its data word was accepted");
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                data_words++;
                check_value("app_wdf_end", app_wdf_end, 1'b1);
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("data word written with no word left in the expected stream");
                end else begin
                    check_value("app_wdf_data", app_wdf_data, exp_data.pop_front());
                end
            end
            if (app_en && app_rdy) begin
                addr_words++;
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("address issued with no address left in the expected list");
                end else begin
                    check_value("app_addr", app_addr, exp_addr.pop_front());
                end
            end
            // record is a single pulse and wr_done follows it
            if (rec_prev) begin
                check_value("rec_wr_en", rec_wr_en, 1'b0);
                check_value("wr_done", wr_done, 1'b1);
            end
            if (rec_wr_en) begin
                rec_cnt++;
                if (exp_rec.size() == 0) begin
                    errors++;
                    $display("fill record written that was not expected");
                end else begin
                    check_value("rec_data", rec_data, exp_rec.pop_front());
                end
            end
            rec_prev = rec_wr_en;
        end
    end

    task automatic queues_drained();
        if (exp_data.size() != 0 || exp_addr.size() != 0 || exp_rec.size() != 0) begin
            errors++;
            $display("fill ended with expected words, addresses or records never written");
        end
    endtask

    task automatic run_fill(input logic fixed);
        int n_wfm;
        int lens [3];
        int total;
        burst_addr_t hdr_addr;
        burst_addr_t fix_addr;
        burst_addr_t base;
        sample_t hdr;
        sample_t whdr;
        sample_t smp;
        sample_t cks;
        fill_rec_t rec;
        n_wfm = 1 + rand_bits(2) % 3;
        // fill header, one header per waveform, data, checksum
        total = 2;
        for (int w = 0; w < n_wfm; w++) begin
            lens[w] = 1 + rand_bits(3);
            total += lens[w] + 1;
        end
        hdr_addr = burst_addr_t'(rand_bits(23));
        fix_addr = burst_addr_t'(rand_bits(23));
        base = fixed ? fix_addr : hdr_addr;
        hdr = '0;
        hdr[127:96] = fill_idx;
        hdr[75:53] = hdr_addr;
        hdr[22:0] = wfm_count_t'(n_wfm);
        exp_data.push_back(hdr);
        // one burst per word at consecutive addresses
        for (int k = 0; k < total; k++) begin
            exp_addr.push_back({burst_addr_t'(base + k), 3'b000});
        end
        rec.total = burst_count_t'(total);
        rec.header = hdr;
        exp_rec.push_back(rec);
        recs_expected++;
        start_addr = hdr_addr;
        wfm_count = wfm_count_t'(n_wfm);
        burst_len = burst_len_t'(lens[0]);
        fixed_start_addr = fix_addr;
        use_fixed_start_addr = fixed;
        fill_start = 1'b1;
        next_cycle();
        fill_start = 1'b0;
        fill_idx++;
        cks = '0;
        for (int w = 0; w < n_wfm; w++) begin
            whdr = '0;
            whdr[22:0] = burst_len_t'(lens[w]);
            whdr[47:32] = 16'(w);
            exp_data.push_back(whdr);
            for (int i = 0; i < lens[w]; i++) begin
                // two idle cycles keep samples out of header cycles
                repeat (2 + rand_bits(2)) next_cycle();
                smp = '0;
                for (int j = 0; j < 4; j++) begin
                    smp = {smp[95:0], rand_bits(32)};
                end
                exp_data.push_back(smp);
                cks ^= smp;
                adc_valid = 1'b1;
                adc_dat = smp;
                // next length must be stable before its header cycle
                if (i == lens[w] - 1 && w + 1 < n_wfm) begin
                    burst_len = burst_len_t'(lens[w + 1]);
                end
                next_cycle();
                adc_valid = 1'b0;
            end
        end
        exp_data.push_back(cks);
        while (rec_cnt < recs_expected) next_cycle();
        while (wr_done) next_cycle();
        queues_drained();
    endtask

    // sample lands in the first waveform header cycle
    task automatic run_collision();
        burst_addr_t hdr_addr;
        sample_t hdr;
        int words_base;
        hdr_addr = burst_addr_t'(rand_bits(23));
        hdr = '0;
        hdr[127:96] = fill_idx;
        hdr[75:53] = hdr_addr;
        hdr[22:0] = 1;
        exp_data.push_back(hdr);
        exp_addr.push_back({hdr_addr, 3'b000});
        words_base = data_words;
        start_addr = hdr_addr;
        wfm_count = 1;
        burst_len = 4;
        use_fixed_start_addr = 1'b0;
        fill_start = 1'b1;
        next_cycle();
        fill_start = 1'b0;
        fill_idx++;
        // fill header cycle
        next_cycle();
        adc_valid = 1'b1;
        adc_dat = {4{rand_bits(32)}};
        next_cycle();
        adc_valid = 1'b0;
        check_value("overrun", overrun, 1'b1);
        while (!sync_err) next_cycle();
        // only the fill header reaches memory
        check_value("words before sync_err", data_words - words_base, 1);
        acq_enabled = 1'b0;
        next_cycle();
        check_value("sync_err", sync_err, 1'b0);
        queues_drained();
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles == cycle_limit) begin
            $display("timeout, run still busy after %0d cycles", cycle_limit);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        acq_enabled = 1'b1;
        fill_start = 1'b0;
        start_addr = '0;
        wfm_count = '0;
        burst_len = '0;
        adc_valid = 1'b0;
        adc_dat = '0;
        app_rdy = 1'b0;
        app_wdf_rdy = 1'b0;
        fixed_start_addr = '0;
        use_fixed_start_addr = 1'b0;
        repeat (4) next_cycle();
        reset = 1'b0;
        repeat (2) next_cycle();
        // second fill takes its addresses from the fixed start
        run_fill(1'b0);
        run_fill(1'b1);
        run_fill(1'b0);
        run_fill(1'b0);
        check_value("fill records", rec_cnt, 4);
        check_value("overrun", overrun, 1'b0);
        check_value("sync_err", sync_err, 1'b0);
        run_collision();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
